//--- rtl/wdt_axi_read.sv
`timescale 1ns/100ps
`default_nettype none

module wdt_axi_read #(
    parameter logic [wdt_pkg::ADDR_BITS-1:0] BASE_ADDR = 32'h1001_0000
) (
    input  logic                           ACLK,
    input  logic                           ARESETn,
    input  logic [wdt_pkg::ID_BITS-1:0]    arid,
    input  logic [wdt_pkg::ADDR_BITS-1:0]  araddr,
    input  logic [wdt_pkg::LEN_BITS-1:0]   arlen,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [wdt_pkg::ID_BITS-1:0]    rid,
    output logic [wdt_pkg::DATA_BITS-1:0]  rdata,
    output logic [1:0]                     rresp,
    output logic                           rlast,
    output logic                           rvalid,
    input  logic                           rready,
    input  logic                           en,
    input  logic [wdt_pkg::DATA_BITS-1:0]  timeout
);

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

    rd_state_e                      state_q;
    logic [wdt_pkg::ID_BITS-1:0]    id_q;
    logic [wdt_pkg::ADDR_BITS-1:0]  addr_q;
    logic [wdt_pkg::LEN_BITS-1:0]   len_q;
    logic [wdt_pkg::LEN_BITS-1:0]   beat_q;
    wdt_pkg::wdt_reg_e              sel;
    logic                           ar_hs;
    logic                           r_hs;

    assign arready = (state_q == RD_IDLE);
    assign rvalid  = (state_q == RD_DATA);
    assign rlast   = rvalid && (beat_q == len_q);
    assign rid     = id_q;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // Register readback; kick is write-only
    assign sel = wdt_pkg::decode_offset(addr_q, BASE_ADDR);

    always_comb begin
        case (sel)
            wdt_pkg::REG_EN:      rdata = {{(wdt_pkg::DATA_BITS-1){1'b0}}, en};
            wdt_pkg::REG_TIMEOUT: rdata = timeout;
            default:              rdata = '0;
        endcase
    end

    assign rresp = (sel == wdt_pkg::REG_NONE) ? wdt_pkg::RESP_SLVERR : wdt_pkg::RESP_OKAY;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state_q <= RD_IDLE;
            beat_q  <= '0;
        end else if (ar_hs) begin
            state_q <= RD_DATA;
            beat_q  <= '0;
        end else if (r_hs) begin
            beat_q <= beat_q + 1'b1;
            if (rlast) state_q <= RD_IDLE;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            id_q   <= arid;
            addr_q <= araddr;
            len_q  <= arlen;
        end else if (r_hs) begin
            addr_q <= addr_q + 32'd4;
        end
    end

endmodule

`default_nettype wire

//--- rtl/wdt_axi_write.sv
`timescale 1ns/100ps
`default_nettype none

module wdt_axi_write #(
    parameter logic [wdt_pkg::ADDR_BITS-1:0] BASE_ADDR = 32'h1001_0000
) (
    input  logic                           ACLK,
    input  logic                           ARESETn,
    input  logic [wdt_pkg::ID_BITS-1:0]    awid,
    input  logic [wdt_pkg::ADDR_BITS-1:0]  awaddr,
    input  logic [wdt_pkg::LEN_BITS-1:0]   awlen,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [wdt_pkg::DATA_BITS-1:0]  wdata,
    input  logic [wdt_pkg::STRB_BITS-1:0]  wstrb,
    input  logic                           wlast,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [wdt_pkg::ID_BITS-1:0]    bid,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    output logic                           reg_we,
    output wdt_pkg::wdt_reg_e              reg_sel,
    output logic [wdt_pkg::DATA_BITS-1:0]  reg_wdata
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e                      state_q;
    wr_state_e                      state_d;
    logic [wdt_pkg::ID_BITS-1:0]    id_q;
    logic [wdt_pkg::ADDR_BITS-1:0]  addr_q;
    logic [wdt_pkg::LEN_BITS-1:0]   len_q;
    logic [wdt_pkg::LEN_BITS-1:0]   beat_q;
    logic                           err_q;
    logic                           aw_hs;
    logic                           w_hs;
    logic                           last_beat;

    assign awready = (state_q == WR_IDLE);
    assign wready  = (state_q == WR_DATA);
    assign bvalid  = (state_q == WR_RESP);

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // WLAST closes the burst; the length is a backstop
    assign last_beat = wlast || (beat_q == len_q);

    // Current beat decode drives the timer strobe
    assign reg_sel   = wdt_pkg::decode_offset(addr_q, BASE_ADDR);
    assign reg_we    = w_hs && (|wstrb) && (reg_sel != wdt_pkg::REG_NONE);
    assign reg_wdata = wdata;

    assign bid   = id_q;
    assign bresp = err_q ? wdt_pkg::RESP_SLVERR : wdt_pkg::RESP_OKAY;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: if (aw_hs) state_d = WR_DATA;
            WR_DATA: if (w_hs && last_beat) state_d = WR_RESP;
            WR_RESP: if (bready) state_d = WR_IDLE;
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state_q <= WR_IDLE;
            beat_q  <= '0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (aw_hs) begin
                beat_q <= '0;
                err_q  <= 1'b0;
            end else if (w_hs) begin
                beat_q <= beat_q + 1'b1;
                // Any unmapped beat fails the whole burst
                if (reg_sel == wdt_pkg::REG_NONE) begin
                    err_q <= 1'b1;
                end
            end
        end
    end

    // Request payload, stepped one word per beat
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            id_q   <= awid;
            addr_q <= awaddr;
            len_q  <= awlen;
        end else if (w_hs) begin
            addr_q <= addr_q + 32'd4;
        end
    end

endmodule

`default_nettype wire

//--- rtl/wdt_pkg.sv
`default_nettype none

package wdt_pkg;

    // AXI field widths
    localparam int unsigned ADDR_BITS = 32;
    localparam int unsigned DATA_BITS = 32;
    localparam int unsigned STRB_BITS = 4;
    localparam int unsigned ID_BITS   = 8;
    localparam int unsigned LEN_BITS  = 4;

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Register offsets from the base address
    localparam logic [ADDR_BITS-1:0] OFFS_EN      = 32'h0000_0100;
    localparam logic [ADDR_BITS-1:0] OFFS_KICK    = 32'h0000_0200;
    localparam logic [ADDR_BITS-1:0] OFFS_TIMEOUT = 32'h0000_0300;

    // Register select, shared by write and read paths
    typedef enum logic [1:0] {
        REG_NONE,
        REG_EN,
        REG_KICK,
        REG_TIMEOUT
    } wdt_reg_e;

    // Map a bus address onto one of the watchdog registers
    function automatic wdt_reg_e decode_offset(
        input logic [ADDR_BITS-1:0] addr,
        input logic [ADDR_BITS-1:0] base
    );
        logic [ADDR_BITS-1:0] offs;
        offs = addr - base;
        case (offs)
            OFFS_EN:      return REG_EN;
            OFFS_KICK:    return REG_KICK;
            OFFS_TIMEOUT: return REG_TIMEOUT;
            default:      return REG_NONE;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rtl/wdt_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module wdt_subsystem #(
    parameter logic [wdt_pkg::ADDR_BITS-1:0] BASE_ADDR = 32'h1001_0000
) (
    input  logic                           ACLK,
    input  logic                           ARESETn,
    input  logic [wdt_pkg::ID_BITS-1:0]    awid,
    input  logic [wdt_pkg::ADDR_BITS-1:0]  awaddr,
    input  logic [wdt_pkg::LEN_BITS-1:0]   awlen,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [wdt_pkg::DATA_BITS-1:0]  wdata,
    input  logic [wdt_pkg::STRB_BITS-1:0]  wstrb,
    input  logic                           wlast,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [wdt_pkg::ID_BITS-1:0]    bid,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [wdt_pkg::ID_BITS-1:0]    arid,
    input  logic [wdt_pkg::ADDR_BITS-1:0]  araddr,
    input  logic [wdt_pkg::LEN_BITS-1:0]   arlen,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [wdt_pkg::ID_BITS-1:0]    rid,
    output logic [wdt_pkg::DATA_BITS-1:0]  rdata,
    output logic [1:0]                     rresp,
    output logic                           rlast,
    output logic                           rvalid,
    input  logic                           rready,
    output logic                           wto
);

    logic                           reg_we;
    wdt_pkg::wdt_reg_e              reg_sel;
    logic [wdt_pkg::DATA_BITS-1:0]  reg_wdata;
    logic                           en;
    logic [wdt_pkg::DATA_BITS-1:0]  timeout;

    // Write channels feed register strobes to the timer
    wdt_axi_write #(
        .BASE_ADDR (BASE_ADDR)
    ) i_write (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .awid      (awid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bid       (bid),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .reg_we    (reg_we),
        .reg_sel   (reg_sel),
        .reg_wdata (reg_wdata)
    );

    // Read channels see the live register values
    wdt_axi_read #(
        .BASE_ADDR (BASE_ADDR)
    ) i_read (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .en      (en),
        .timeout (timeout)
    );

    wdt_timer i_timer (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .reg_we    (reg_we),
        .reg_sel   (reg_sel),
        .reg_wdata (reg_wdata),
        .en        (en),
        .timeout   (timeout),
        .wto       (wto)
    );

endmodule

`default_nettype wire

//--- rtl/wdt_timer.sv
`timescale 1ns/100ps
`default_nettype none

module wdt_timer (
    input  logic                           ACLK,
    input  logic                           ARESETn,
    input  logic                           reg_we,
    input  wdt_pkg::wdt_reg_e              reg_sel,
    input  logic [wdt_pkg::DATA_BITS-1:0]  reg_wdata,
    output logic                           en,
    output logic [wdt_pkg::DATA_BITS-1:0]  timeout,
    output logic                           wto
);

    logic                           en_q;
    logic [wdt_pkg::DATA_BITS-1:0]  timeout_q;
    logic [wdt_pkg::DATA_BITS-1:0]  count_q;
    logic                           expired;

    assign en      = en_q;
    assign timeout = timeout_q;

    assign expired = (count_q == timeout_q);
    assign wto     = en_q && expired;

    // Software-visible registers
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            en_q      <= 1'b0;
            timeout_q <= '0;
        end else if (reg_we) begin
            case (reg_sel)
                wdt_pkg::REG_EN:      en_q      <= reg_wdata[0];
                wdt_pkg::REG_TIMEOUT: timeout_q <= reg_wdata;
                default:              ;
            endcase
        end
    end

    // Any register write restarts the count, kick included
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            count_q <= '0;
        end else if (reg_we || !en_q) begin
            count_q <= '0;
        end else if (!expired) begin
            count_q <= count_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the watchdog testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_wdt_subsystem \
    -Mdir obj_dir

./obj_dir/Vtb_wdt_subsystem

//--- sources.f
rtl/wdt_pkg.sv
rtl/wdt_timer.sv
rtl/wdt_axi_write.sv
rtl/wdt_axi_read.sv
rtl/wdt_subsystem.sv
test/wdt_properties.sv
test/tb_wdt_subsystem.sv

//--- test/tb_wdt_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_wdt_subsystem;

    localparam logic [31:0] BASE       = 32'h1001_0000;
    localparam int          CLK_PERIOD = 20;
    localparam int          NUM_TXN    = 80;
    localparam int          MAX_TO     = 24;
    localparam int          MAX_GAP    = 3;
    // Longest burst per transaction with gaps and stalls on both channels
    localparam int          TXN_CYCLES = 16 * (MAX_GAP + 1) * 4 + 40;
    localparam int          LIMIT      = (NUM_TXN * TXN_CYCLES + 8 * MAX_TO + 400) * CLK_PERIOD;

    localparam logic [1:0] SEL_NONE = 2'd0;
    localparam logic [1:0] SEL_EN   = 2'd1;
    localparam logic [1:0] SEL_KICK = 2'd2;
    localparam logic [1:0] SEL_TO   = 2'd3;

    logic        ACLK;
    logic        ARESETn;
    logic [7:0]  awid;
    logic [31:0] awaddr;
    logic [3:0]  awlen;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic [7:0]  bid;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  arid;
    logic [31:0] araddr;
    logic [3:0]  arlen;
    logic        arvalid;
    logic        arready;
    logic [7:0]  rid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic        wto;

    // Reference model state
    logic        m_en = 1'b0;
    logic [31:0] m_to = '0;
    logic [31:0] m_cnt = '0;
    logic        pend_we = 1'b0;
    logic [1:0]  pend_sel = SEL_NONE;
    logic [31:0] pend_data = '0;
    logic [31:0] lcg_state = 32'd10;

    wdt_subsystem #(
        .BASE_ADDR (BASE)
    ) i_dut (
        .ACLK    (ACLK),    .ARESETn (ARESETn),
        .awid    (awid),    .awaddr  (awaddr),  .awlen   (awlen),
        .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wstrb   (wstrb),   .wlast   (wlast),
        .wvalid  (wvalid),  .wready  (wready),
        .bid     (bid),     .bresp   (bresp),   .bvalid  (bvalid),  .bready (bready),
        .arid    (arid),    .araddr  (araddr),  .arlen   (arlen),
        .arvalid (arvalid), .arready (arready),
        .rid     (rid),     .rdata   (rdata),   .rresp   (rresp),
        .rlast   (rlast),   .rvalid  (rvalid),  .rready  (rready),
        .wto     (wto)
    );

    always #(CLK_PERIOD / 2) ACLK = ~ACLK;

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        // Strong upper state bits land in the low half of the result
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic logic [1:0] reg_of(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - BASE;
        if (offs == wdt_pkg::OFFS_EN) return SEL_EN;
        if (offs == wdt_pkg::OFFS_KICK) return SEL_KICK;
        if (offs == wdt_pkg::OFFS_TIMEOUT) return SEL_TO;
        return SEL_NONE;
    endfunction

    // Mostly register starts, some that walk into a register, some anywhere
    function automatic logic [31:0] pick_addr();
        logic [31:0] r;
        r = lcg();
        case (r[2:0])
            3'd0, 3'd1: return BASE + wdt_pkg::OFFS_EN;
            3'd2:       return BASE + wdt_pkg::OFFS_KICK;
            3'd3, 3'd4: return BASE + wdt_pkg::OFFS_TIMEOUT;
            3'd5:       return BASE + wdt_pkg::OFFS_TIMEOUT - {28'd0, r[9:8], 2'b00};
            default:    return BASE + {20'd0, r[19:10], 2'b00};
        endcase
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge ACLK);
    endtask

    task automatic write_burst(input logic [7:0] id, input logic [31:0] addr,
                               input logic [3:0] len, input logic rand_beats,
                               input logic [31:0] data);
        logic [31:0] r;
        logic [31:0] beat_addr;
        logic [1:0]  sel;
        logic        err;
        err = 1'b0;
        awid = id;
        awaddr = addr;
        awlen = len;
        awvalid = 1'b1;
        while (!awready) @(negedge ACLK);
        @(negedge ACLK);
        awvalid = 1'b0;
        for (int n = 0; n <= int'(len); n++) begin
            r = lcg();
            if (rand_beats) idle(int'(r[1:0]));
            beat_addr = addr + (n << 2);
            r = lcg();
            wdata = rand_beats ? (r % MAX_TO) : data;
            if (!rand_beats || r[31:30] != 2'b00) begin
                wstrb = (r[27:24] == 4'h0 || !rand_beats) ? 4'hF : r[27:24];
            end else begin
                wstrb = 4'h0;
            end
            wlast = (n == int'(len));
            wvalid = 1'b1;
            while (!wready) @(negedge ACLK);
            // Beat transfers at the coming rising edge
            sel = reg_of(beat_addr);
            if (sel == SEL_NONE) begin
                err = 1'b1;
            end else if (wstrb != 4'h0) begin
                pend_sel = sel;
                pend_data = wdata;
                pend_we = 1'b1;
            end
            @(negedge ACLK);
            pend_we = 1'b0;
            wvalid = 1'b0;
            wlast = 1'b0;
        end
        r = lcg();
        bready = r[0];
        while (!(bvalid && bready)) begin
            @(negedge ACLK);
            r = lcg();
            bready = r[0];
        end
        check({24'd0, bid}, {24'd0, id}, "BID");
        check({30'd0, bresp}, {30'd0, err ? wdt_pkg::RESP_SLVERR : wdt_pkg::RESP_OKAY},
              "BRESP");
        @(negedge ACLK);
        bready = 1'b0;
        check({31'd0, bvalid}, 32'd0, "BVALID after accept");
    endtask

    task automatic read_burst(input logic [7:0] id, input logic [31:0] addr,
                              input logic [3:0] len);
        logic [31:0] r;
        logic [31:0] beat_addr;
        logic [31:0] exp_data;
        logic [1:0]  sel;
        arid = id;
        araddr = addr;
        arlen = len;
        arvalid = 1'b1;
        while (!arready) @(negedge ACLK);
        @(negedge ACLK);
        arvalid = 1'b0;
        for (int n = 0; n <= int'(len); n++) begin
            beat_addr = addr + (n << 2);
            r = lcg();
            rready = r[0] | r[1];
            while (!(rvalid && rready)) begin
                @(negedge ACLK);
                r = lcg();
                rready = r[0] | r[1];
            end
            sel = reg_of(beat_addr);
            exp_data = (sel == SEL_EN) ? {31'd0, m_en} : (sel == SEL_TO) ? m_to : 32'd0;
            check({24'd0, rid}, {24'd0, id}, "RID");
            check(rdata, exp_data, "RDATA");
            check({30'd0, rresp}, {30'd0, (sel == SEL_NONE) ? wdt_pkg::RESP_SLVERR
                                                             : wdt_pkg::RESP_OKAY}, "RRESP");
            check({31'd0, rlast}, {31'd0, n == int'(len)}, "RLAST");
            @(negedge ACLK);
            rready = 1'b0;
        end
        check({31'd0, rvalid}, 32'd0, "RVALID after last beat");
    endtask

    // Timer model, advanced at every rising edge
    always @(posedge ACLK) begin
        if (!ARESETn) begin
            m_en = 1'b0;
            m_to = '0;
            m_cnt = '0;
        end else begin
            if (pend_we || !m_en) m_cnt = '0;
            else if (m_cnt != m_to) m_cnt = m_cnt + 32'd1;
            if (pend_we && pend_sel == SEL_EN) m_en = pend_data[0];
            if (pend_we && pend_sel == SEL_TO) m_to = pend_data;
        end
    end

    always @(negedge ACLK) begin
        if (ARESETn === 1'b1) begin
            check({31'd0, wto}, {31'd0, m_en && (m_cnt == m_to)}, "wto");
        end
    end

    initial begin
        #(LIMIT);
        $display("Timeout: the run did not complete, a handshake never finished");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] waddr;
        logic [31:0] raddr;
        logic [3:0]  wlen;
        logic [3:0]  rlen;
        ACLK = 1'b0;
        ARESETn = 1'b0;
        {awid, awaddr, awlen, awvalid} = '0;
        {wdata, wstrb, wlast, wvalid, bready} = '0;
        {arid, araddr, arlen, arvalid, rready} = '0;
        repeat (8) @(negedge ACLK);
        ARESETn = 1'b1;
        @(negedge ACLK);
        check({31'd0, awready}, 32'd1, "AWREADY after reset");
        check({31'd0, arready}, 32'd1, "ARREADY after reset");
        check({28'd0, wready, bvalid, rvalid, rlast}, 32'd0, "channel valids after reset");

        // Exact expiry, kick before and after expiry, then disable
        write_burst(8'h01, BASE + wdt_pkg::OFFS_TIMEOUT, 4'd0, 1'b0, 32'd7);
        write_burst(8'h02, BASE + wdt_pkg::OFFS_EN, 4'd0, 1'b0, 32'd1);
        idle(12);
        read_burst(8'h03, BASE + wdt_pkg::OFFS_TIMEOUT, 4'd0);
        write_burst(8'h04, BASE + wdt_pkg::OFFS_KICK, 4'd0, 1'b0, 32'hFFFF_FFFF);
        idle(3);
        write_burst(8'h05, BASE + wdt_pkg::OFFS_KICK, 4'd0, 1'b0, 32'd0);
        idle(12);
        read_burst(8'h06, BASE + wdt_pkg::OFFS_KICK, 4'd2);
        write_burst(8'h07, BASE + wdt_pkg::OFFS_EN, 4'd0, 1'b0, 32'd0);
        idle(40);

        // Random overlapping traffic with stalls
        for (int i = 0; i < NUM_TXN; i++) begin
            waddr = pick_addr();
            raddr = pick_addr();
            r = lcg();
            wlen = (r[3:0] == 4'd0) ? r[7:4] : {2'b00, r[9:8]};
            rlen = (r[13:10] == 4'd0) ? r[17:14] : {2'b00, r[19:18]};
            fork
                write_burst(r[27:20], waddr, wlen, 1'b1, 32'd0);
                read_burst(~r[27:20], raddr, rlen);
            join
            idle(int'(r[30:28]));
        end
        idle(2 * MAX_TO);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/wdt_properties.sv
`timescale 1ns/100ps
`default_nettype none

module wdt_properties (
    input logic        ACLK,
    input logic        ARESETn,
    input logic        awvalid,
    input logic        awready,
    input logic        bvalid,
    input logic        bready,
    input logic [7:0]  bid,
    input logic        rvalid,
    input logic        rready,
    input logic [7:0]  rid,
    input logic [31:0] rdata,
    input logic        rlast,
    input logic        wto,
    input logic        reg_we
);

    logic wr_busy;

    // Write in flight from the AW transfer until the B transfer
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_busy <= 1'b0;
        end else if (awvalid && awready) begin
            wr_busy <= 1'b1;
        end else if (bvalid && bready) begin
            wr_busy <= 1'b0;
        end
    end

    a_b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        bvalid && !bready |=> bvalid && $stable(bid))
        else $error("B response dropped or changed before BREADY");

    a_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        rvalid && !rready |=> rvalid && $stable(rid) && $stable(rlast))
        else $error("R beat dropped or changed before RREADY");

    // Register data may only move when a write lands
    a_rdata_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        rvalid && !rready && !reg_we |=> $stable(rdata))
        else $error("RDATA changed while stalled");

    a_aw_busy: assert property (@(posedge ACLK) disable iff (!ARESETn)
        wr_busy |-> !awready)
        else $error("AWREADY high during a write");

    // Saturated count keeps wto up until the next register write
    a_wto_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        wto && !reg_we |=> wto)
        else $error("wto dropped without a register write");

endmodule

bind wdt_subsystem wdt_properties i_props (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .awvalid (awvalid),
    .awready (awready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bid     (bid),
    .rvalid  (rvalid),
    .rready  (rready),
    .rid     (rid),
    .rdata   (rdata),
    .rlast   (rlast),
    .wto     (wto),
    .reg_we  (reg_we)
);

`default_nettype wire
